// ==== list.f ====
rtl/pulse_capture_pkg.sv
rtl/pulse_cfg_decode.sv
rtl/pulse_gen.sv
rtl/capture_writer.sv
rtl/pulse_capture_top.sv
tests/tb_clock_gen.sv
tests/pulse_capture_sva.sv
tests/tb_pulse_capture.sv

// ==== rtl/capture_writer.sv ====
`default_nettype none
`timescale 1ns/1ps

module capture_writer (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic                               i_trig,     // from pulse_gen
    input  pulse_capture_pkg::cap_cfg_t        i_cfg,      // len, base
    input  logic [pulse_capture_pkg::ADC_W-1:0] i_adc_data,
    output pulse_capture_pkg::bram_wr_t        o_bram      // write port
);
    import pulse_capture_pkg::*;

    logic [ADC_W-1:0]      adc_q;   // sample from last cycle
    logic                  busy_q;  // writes in progress
    logic [CAP_LEN_W-1:0]  rem_q;   // writes left incl. current
    logic [CAP_ADDR_W-1:0] addr_q;  // current write address
    logic                  trig_ok; // trigger accepted

    // idle only, len 0 gives no capture
    assign trig_ok = i_trig && !busy_q;

    // --------------------------------------------------
    // sample pipe
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        adc_q <= i_adc_data;                // one cycle behind the pins
    end

    // --------------------------------------------------
    // write sequencing
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            rem_q  <= '0;
        end else if (!busy_q) begin
            if (trig_ok && (i_cfg.len != '0)) begin
                busy_q <= 1'b1;             // first write next cycle
                rem_q  <= i_cfg.len;
            end
        end else begin
            rem_q <= rem_q - 1'b1;
            if (rem_q == CAP_LEN_W'(1)) begin
                busy_q <= 1'b0;             // that was the last write
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trig_ok) begin
            addr_q <= i_cfg.base;           // latched at trigger
        end else if (busy_q) begin
            addr_q <= addr_q + 1'b1;        // wraps at address width
        end
    end

    // write k carries the sample seen k cycles after trigger
    assign o_bram = '{we: busy_q, addr: addr_q, data: adc_q};

endmodule

`default_nettype wire

// ==== rtl/pulse_capture_pkg.sv ====
`default_nettype none

package pulse_capture_pkg;

    // --------------------------------------------------
    // field widths
    // --------------------------------------------------
    localparam int WIDTH_W    = 11; // pulse width and pulse count
    localparam int GAP_W      = 9;  // gap, in GAP_UNIT steps
    localparam int CAP_LEN_W  = 10; // samples per capture
    localparam int CAP_ADDR_W = 10; // buffer address
    localparam int ADC_W      = 12; // adc sample
    localparam int CFG_W      = 32; // config word

    localparam int CAP_PAD_W  = CFG_W - 1 - CAP_LEN_W - CAP_ADDR_W; // unused cap bits

    localparam logic KIND_PULSE = 1'b0; // bit 31 low, pulse setup
    localparam logic KIND_CAP   = 1'b1; // bit 31 high, capture setup

    // --------------------------------------------------
    // settings
    // --------------------------------------------------
    typedef struct packed {
        logic [WIDTH_W-1:0] width;  // high cycles per pulse
        logic [WIDTH_W-1:0] num;    // pulses per burst
        logic [GAP_W-1:0]   gap;    // low time between pulses
    } pulse_cfg_t;                  // fills all 31 bits

    typedef struct packed {
        logic [CAP_PAD_W-1:0]  pad;  // zero
        logic [CAP_LEN_W-1:0]  len;  // writes per trigger
        logic [CAP_ADDR_W-1:0] base; // first buffer address
    } cap_cfg_t;

    typedef struct packed {
        logic       kind;           // KIND_PULSE here
        pulse_cfg_t cfg;
    } pulse_word_t;

    typedef struct packed {
        logic     kind;             // KIND_CAP here
        cap_cfg_t cfg;
    } cap_word_t;

    // one config word, two readings picked by bit 31
    typedef union packed {
        pulse_word_t pulse;
        cap_word_t   cap;
    } cfg_word_t;

    typedef struct packed {
        logic                  we;   // write strobe
        logic [CAP_ADDR_W-1:0] addr;
        logic [ADC_W-1:0]      data;
    } bram_wr_t;

endpackage

`default_nettype wire

// ==== rtl/pulse_capture_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module pulse_capture_top #(
    parameter int GAP_UNIT = 4                          // cycles per gap step
) (
    input  logic                                clk,
    input  logic                                i_rst_n,

    // config port
    input  logic                                i_cfg_valid,
    input  pulse_capture_pkg::cfg_word_t        i_cfg_word,

    // burst control
    input  logic                                i_start,
    output logic                                o_pulse,
    output logic                                o_trig,
    output logic                                o_done,

    // adc in, buffer out
    input  logic [pulse_capture_pkg::ADC_W-1:0] i_adc_data,
    output pulse_capture_pkg::bram_wr_t         o_bram
);
    import pulse_capture_pkg::*;

    pulse_cfg_t pulse_cfg;                      // decode -> pulse_gen
    cap_cfg_t   cap_cfg;                        // decode -> capture_writer

    // --------------------------------------------------
    // config decode
    // --------------------------------------------------
    pulse_cfg_decode pulse_cfg_decode_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_cfg_valid (i_cfg_valid),
        .i_cfg_word  (i_cfg_word),
        .o_pulse_cfg (pulse_cfg),
        .o_cap_cfg   (cap_cfg)
    );

    // --------------------------------------------------
    // pulse generator
    // --------------------------------------------------
    pulse_gen #(
        .GAP_UNIT (GAP_UNIT)
    ) pulse_gen_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_cfg   (pulse_cfg),
        .o_pulse (o_pulse),
        .o_trig  (o_trig),                      // also starts capture
        .o_done  (o_done)
    );

    // --------------------------------------------------
    // adc capture
    // --------------------------------------------------
    capture_writer capture_writer_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_trig     (o_trig),
        .i_cfg      (cap_cfg),
        .i_adc_data (i_adc_data),
        .o_bram     (o_bram)
    );

endmodule

`default_nettype wire

// ==== rtl/pulse_cfg_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module pulse_cfg_decode (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_cfg_valid,  // one-cycle strobe
    input  pulse_capture_pkg::cfg_word_t  i_cfg_word,
    output pulse_capture_pkg::pulse_cfg_t o_pulse_cfg,  // to pulse_gen
    output pulse_capture_pkg::cap_cfg_t   o_cap_cfg     // to capture_writer
);
    import pulse_capture_pkg::*;

    pulse_cfg_t pulse_q;        // held burst settings
    cap_cfg_t   cap_q;          // held capture settings
    pulse_cfg_t pulse_in;       // pulse view with zero fields clamped
    logic       is_pulse;       // kind bit says pulse
    logic       is_cap;         // kind bit says capture

    // --------------------------------------------------
    // word decode
    // --------------------------------------------------
    assign is_pulse = i_cfg_valid && (i_cfg_word.pulse.kind == KIND_PULSE);
    assign is_cap   = i_cfg_valid && (i_cfg_word.cap.kind == KIND_CAP);

    always_comb begin
        pulse_in = i_cfg_word.pulse.cfg;            // pulse reading of the word
        if (pulse_in.width == '0) begin
            pulse_in.width = WIDTH_W'(1);           // zero width acts as 1
        end
        if (pulse_in.num == '0) begin
            pulse_in.num = WIDTH_W'(1);             // zero count acts as 1
        end
    end

    // --------------------------------------------------
    // setting registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pulse_q.width <= WIDTH_W'(1);   // one cycle wide
            pulse_q.num   <= WIDTH_W'(1);   // single pulse
            pulse_q.gap   <= '0;
        end else if (is_pulse) begin
            pulse_q <= pulse_in;            // capture side untouched
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            cap_q <= '0;                    // len 0 captures nothing
        end else if (is_cap) begin
            cap_q     <= i_cfg_word.cap.cfg; // pulse side untouched
            cap_q.pad <= '0;                // keep pad clean
        end
    end

    assign o_pulse_cfg = pulse_q;
    assign o_cap_cfg   = cap_q;

endmodule

`default_nettype wire

// ==== rtl/pulse_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module pulse_gen #(
    parameter int GAP_UNIT = 4              // cycles per gap step, 1 or more
) (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_start,  // one-cycle strobe
    input  pulse_capture_pkg::pulse_cfg_t i_cfg,    // width, num already >= 1
    output logic                          o_pulse,
    output logic                          o_trig,   // first pulse marker
    output logic                          o_done    // burst finished
);
    import pulse_capture_pkg::*;

    localparam int GCNT_W = GAP_W + $clog2(GAP_UNIT + 1); // holds gap * GAP_UNIT

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HIGH,
        ST_GAP
    } state_t;

    state_t             state_q;
    logic [WIDTH_W-1:0] width_q;    // width for this burst
    logic [GAP_W-1:0]   gap_q;      // gap for this burst
    logic [WIDTH_W-1:0] wcnt_q;     // high cycles left, minus 1
    logic [GCNT_W-1:0]  gcnt_q;     // low cycles left, minus 1
    logic [WIDTH_W-1:0] rem_q;      // pulses left incl. current
    logic [GCNT_W-1:0]  gap_cycles; // low run length
    logic               start_ok;   // start taken this cycle
    logic               high_end;   // last cycle of a high run
    logic               last_pulse; // current pulse is the final one

    assign start_ok   = (state_q == ST_IDLE) && i_start;
    assign high_end   = (state_q == ST_HIGH) && (wcnt_q == '0);
    assign last_pulse = (rem_q == WIDTH_W'(1));
    assign gap_cycles = GCNT_W'(gap_q) * GCNT_W'(GAP_UNIT);

    // --------------------------------------------------
    // burst settings, frozen while running
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (start_ok) begin
            width_q <= i_cfg.width;
            gap_q   <= i_cfg.gap;
        end
    end

    // --------------------------------------------------
    // sequencer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            wcnt_q  <= '0;
            gcnt_q  <= '0;
            rem_q   <= '0;
            o_trig  <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_trig <= 1'b0;                         // strobes default low
            o_done <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (i_start) begin
                        state_q <= ST_HIGH;         // first pulse next cycle
                        o_trig  <= 1'b1;            // lines up with pulse 1
                        wcnt_q  <= i_cfg.width - 1'b1;
                        rem_q   <= i_cfg.num;
                    end
                end
                ST_HIGH: begin
                    if (!high_end) begin
                        wcnt_q <= wcnt_q - 1'b1;
                    end else if (last_pulse) begin
                        state_q <= ST_IDLE;         // idle while done is high
                        o_done  <= 1'b1;
                    end else if (gap_cycles == '0) begin
                        wcnt_q <= width_q - 1'b1;   // no gap, next pulse abuts
                        rem_q  <= rem_q - 1'b1;
                    end else begin
                        state_q <= ST_GAP;
                        gcnt_q  <= gap_cycles - 1'b1;
                    end
                end
                ST_GAP: begin
                    if (gcnt_q == '0) begin
                        state_q <= ST_HIGH;         // next pulse
                        wcnt_q  <= width_q - 1'b1;
                        rem_q   <= rem_q - 1'b1;
                    end else begin
                        gcnt_q <= gcnt_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;             // recover from bad code
                end
            endcase
        end
    end

    assign o_pulse = (state_q == ST_HIGH); // high for every ST_HIGH cycle

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the pulse capture testbench with verilator
set -e

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pulse_capture -f list.f -Mdir obj_dir -o tb_pulse_capture

./obj_dir/tb_pulse_capture +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

# a run counts as good only when the pass line is in the log
if grep -q '^test passed$' sim.log; then
    exit 0
fi
exit 1

// ==== tests/pulse_capture_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

module pulse_capture_sva (
    input logic                        clk,
    input logic                        i_rst_n,
    input logic                        i_start,
    input logic                        o_pulse,
    input logic                        o_trig,
    input logic                        o_done,
    input pulse_capture_pkg::bram_wr_t o_bram
);

    int unsigned fail_count = 0;    // read by the testbench at the end
    logic        run_q;             // burst from trig up to its done cycle
    logic        start_ok;          // start the generator has to take

    // the done cycle is already idle
    assign start_ok = i_start && (!run_q || o_done);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            run_q <= 1'b0;
        end else if (start_ok) begin
            run_q <= 1'b1;
        end else if (o_done) begin
            run_q <= 1'b0;
        end
    end

    // --------------------------------------------------
    // reset and strobe timing
    // --------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk)
        !i_rst_n |=> (!o_pulse && !o_trig && !o_done && !o_bram.we))
        else begin fail_count++; $error("outputs active in or right after reset"); end

    a_trig_follows_start: assert property (@(posedge clk) disable iff (!i_rst_n)
        start_ok |=> o_trig)
        else begin fail_count++; $error("accepted start gave no trigger"); end

    a_trig_needs_start: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_trig |-> $past(start_ok))
        else begin fail_count++; $error("trigger without an accepted start"); end

    a_trig_with_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_trig |-> o_pulse)
        else begin fail_count++; $error("trigger not aligned with the first pulse"); end

    a_done_after_high: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_done |-> ($past(o_pulse) && !o_pulse && run_q))
        else begin fail_count++; $error("done not right after the last high cycle"); end

    a_done_single: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_done |=> !o_done)
        else begin fail_count++; $error("done held longer than one cycle"); end

endmodule

bind pulse_capture_top pulse_capture_sva pulse_capture_sva_inst (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_start (i_start),
    .o_pulse (o_pulse),
    .o_trig  (o_trig),
    .o_done  (o_done),
    .o_bram  (o_bram)
);

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,         // clock period
    parameter int RST_CYCLES = 4,           // rising edges with reset low
    parameter int REL_DELAY  = 10           // release offset after the edge
) (
    output logic o_clk,
    output logic o_rst_n                    // synchronous, active low
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;                     // low from time zero
        repeat (RST_CYCLES) @(posedge o_clk);
        #(REL_DELAY);
        o_rst_n = 1'b1;                     // released like any other input
    end

endmodule

`default_nettype wire

// ==== tests/tb_pulse_capture.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_pulse_capture;
    import pulse_capture_pkg::*;

    localparam int GAP_UNIT       = 4;          // cycles per gap step
    localparam int TIMEOUT_CYCLES = 20000;      // well above the whole run
    localparam int DRIVE_DELAY    = 10;         // ns after the rising edge

    logic                  clk;
    logic                  rst_n;
    logic                  i_cfg_valid;
    cfg_word_t             i_cfg_word;
    logic                  i_start;
    logic [ADC_W-1:0]      i_adc_data = '0;
    logic                  o_pulse;
    logic                  o_trig;
    logic                  o_done;
    bram_wr_t              o_bram;

    int                    cyc = 0;             // rising edges so far
    int                    tb_errors = 0;
    int unsigned           adc_rnd;
    logic [ADC_W-1:0]      adc_hist [0:TIMEOUT_CYCLES]; // sample of each cycle

    int                    model_w = 1;         // settings the DUT should hold
    int                    model_n = 1;
    int                    model_g = 0;
    int                    model_len = 0;
    int                    model_base = 0;

    int                    cap_left;            // capture tracker
    int                    cap_k;
    int                    cap_t;
    logic [CAP_ADDR_W-1:0] cap_base;
    logic                  cap_busy;
    logic [CAP_ADDR_W-1:0] exp_addr;
    logic                  in_burst;            // burst tracker
    int                    hi_cnt;
    int                    low_run;
    int                    gap_runs;
    int                    exp_hi;
    int                    exp_low;
    int                    exp_gaps;

    tb_clock_gen tb_clock_gen_inst (.o_clk(clk), .o_rst_n(rst_n));

    pulse_capture_top #(.GAP_UNIT(GAP_UNIT)) pulse_capture_top_inst (
        .clk(clk), .i_rst_n(rst_n), .i_cfg_valid(i_cfg_valid), .i_cfg_word(i_cfg_word),
        .i_start(i_start), .o_pulse(o_pulse), .o_trig(o_trig), .o_done(o_done),
        .i_adc_data(i_adc_data), .o_bram(o_bram)
    );

    task automatic report_mismatch(input string name, input int expected, input int actual);
        tb_errors++;
        $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                 $time, name, expected, actual);
    endtask

    task automatic report_fault(input string msg);
        tb_errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    function automatic int rand_below(input int n);
        int unsigned r;
        r = $urandom;
        return int'(r % n);
    endfunction

    // high cycles plus the inner gaps
    function automatic int burst_cycles();
        return model_w * model_n + (model_n - 1) * model_g * GAP_UNIT;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic send_pulse_cfg(input int width, input int num, input int gap);
        cfg_word_t word;
        word                 = '0;
        word.pulse.kind      = KIND_PULSE;
        word.pulse.cfg.width = width[WIDTH_W-1:0];
        word.pulse.cfg.num   = num[WIDTH_W-1:0];
        word.pulse.cfg.gap   = gap[GAP_W-1:0];
        i_cfg_word  = word;
        i_cfg_valid = 1'b1;
        model_w     = (width == 0) ? 1 : width;     // zero acts as 1
        model_n     = (num == 0) ? 1 : num;
        model_g     = gap;
        next_cycle();
        i_cfg_valid = 1'b0;
        next_cycle();                               // start 2 cycles later at the earliest
    endtask

    task automatic send_cap_cfg(input int len, input int base);
        cfg_word_t word;
        word              = '0;
        word.cap.kind     = KIND_CAP;
        word.cap.cfg.len  = len[CAP_LEN_W-1:0];
        word.cap.cfg.base = base[CAP_ADDR_W-1:0];
        i_cfg_word  = word;
        i_cfg_valid = 1'b1;
        model_len   = len;
        model_base  = base;
        next_cycle();
        i_cfg_valid = 1'b0;
        next_cycle();
    endtask

    // returns in the trigger cycle when the start is taken
    task automatic fire_start();
        i_start = 1'b1;
        next_cycle();
        i_start = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!o_done) @(negedge clk);
        next_cycle();
    endtask

    task automatic wait_capture_idle();
        while (cap_left != 0) next_cycle();         // tracker moves at negedge only
    endtask

    // --------------------------------------------------
    // watchdog and adc source
    // --------------------------------------------------
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", cyc);
            $display("test failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        #(DRIVE_DELAY);
        adc_rnd    = $urandom;
        i_adc_data = adc_rnd[ADC_W-1:0];            // fresh sample every cycle
    end

    // --------------------------------------------------
    // monitor at mid-cycle where outputs are settled
    // --------------------------------------------------
    always @(negedge clk) begin
        adc_hist[cyc] = i_adc_data;
        if (!rst_n) begin
            cap_left = 0;
            in_burst = 1'b0;
        end else begin
            cap_busy = (cap_left != 0);             // busy before this cycle's write
            if (cap_busy) begin
                exp_addr = cap_base + cap_k[CAP_ADDR_W-1:0];    // wraps like the buffer
                assert (o_bram.we) else report_mismatch("o_bram.we", 1, 0);
                assert (o_bram.addr == exp_addr)
                    else report_mismatch("o_bram.addr", int'(exp_addr), int'(o_bram.addr));
                assert (o_bram.data == adc_hist[cap_t + cap_k])
                    else report_mismatch("o_bram.data", int'(adc_hist[cap_t + cap_k]),
                                         int'(o_bram.data));
                cap_left--;
                cap_k++;
            end else begin
                assert (!o_bram.we) else report_fault("buffer write outside a capture");
            end
            if (o_trig && !cap_busy) begin          // trigger during a capture is dropped
                cap_left = model_len;
                cap_k    = 0;
                cap_t    = cyc;
                cap_base = model_base[CAP_ADDR_W-1:0];
            end
            if (o_trig) begin
                in_burst = 1'b1;
                hi_cnt   = 0;
                low_run  = 0;
                gap_runs = 0;
                exp_hi   = model_w * model_n;
                exp_low  = model_g * GAP_UNIT;
                exp_gaps = (exp_low == 0) ? 0 : model_n - 1;
            end
            if (in_burst) begin
                if (o_pulse) begin
                    if (low_run != 0) begin
                        assert (low_run == exp_low)
                            else report_mismatch("o_pulse low run", exp_low, low_run);
                        gap_runs++;
                    end
                    low_run = 0;
                    hi_cnt++;
                end else if (o_done) begin
                    assert (hi_cnt == exp_hi)
                        else report_mismatch("o_pulse high cycles", exp_hi, hi_cnt);
                    assert (gap_runs == exp_gaps)
                        else report_mismatch("o_pulse gaps", exp_gaps, gap_runs);
                    in_burst = 1'b0;
                end else begin
                    low_run++;
                end
            end else begin
                assert (!o_pulse) else report_fault("pulse high outside a burst");
            end
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        int          sel;
        int unsigned sva_errors;
        i_cfg_valid = 1'b0;
        i_cfg_word  = '0;
        i_start     = 1'b0;
        void'($urandom(32'h78c5_8b6a));
        @(posedge rst_n);
        repeat (2) next_cycle();

        send_pulse_cfg(0, 0, 2);                    // zero width and count
        send_cap_cfg(0, 0);                         // len 0 writes nothing
        fire_start();
        wait_done();

        send_cap_cfg(12, 1018);                     // runs past the top address
        send_pulse_cfg(3, 4, 1);                    // capture settings kept
        fire_start();
        wait_done();
        wait_capture_idle();

        fire_start();                               // second start mid-burst
        repeat (3) next_cycle();
        fire_start();
        wait_done();

        send_pulse_cfg(2, 3, 2);
        fire_start();
        repeat (burst_cycles()) next_cycle();       // lands on the done cycle
        fire_start();
        wait_done();

        for (int i = 0; i < 24; i++) begin
            sel = rand_below(3);
            if (sel != 1) send_pulse_cfg(rand_below(8), rand_below(6), rand_below(4));
            if (sel != 0) send_cap_cfg(rand_below(48), rand_below(1024));
            fire_start();
            wait_done();
            repeat (rand_below(3)) next_cycle();
        end

        wait_capture_idle();
        repeat (4) next_cycle();
        sva_errors = pulse_capture_top_inst.pulse_capture_sva_inst.fail_count;
        $display("errors: %0d testbench checks, %0d assertions", tb_errors, sva_errors);
        if (tb_errors == 0 && sva_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
